// File: div_checker.sv
// testbench monitor that predicts each divider result and counts checks and errors
module div_checker (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        valid,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic        is_signed,
    input  logic [63:0] hilo,
    output int          checks,
    output int          errors
);
    timeunit 1ns;
    timeprecision 1ps;

    // edge E counts as 1 and the result register loads at E+17
    localparam int result_edge = 18;

    logic        armed         = 1'b0;
    logic        valid_prev    = 1'b0;
    logic        reset_checked = 1'b0;
    logic        flush_seen    = 1'b0;
    int          edge_cnt      = 0;
    int          checks_n      = 0;
    int          errors_n      = 0;
    logic [31:0] a_cap;
    logic [31:0] b_cap;
    logic        sgn_cap;
    logic [63:0] exp_v;

    assign checks = checks_n;
    assign errors = errors_n;

    // truncating division in 64 bits, so the most negative dividend wraps as expected
    function automatic logic [63:0] expected_hilo(input logic [31:0] x, input logic [31:0] y,
                                                  input logic sgn);
        longint nx;
        longint ny;
        longint qv;
        longint rv;
        if (sgn) begin
            nx = longint'($signed(x));
            ny = longint'($signed(y));
        end else begin
            nx = longint'({32'h0, x});
            ny = longint'({32'h0, y});
        end
        qv = nx / ny;
        rv = nx % ny;
        return {rv[31:0], qv[31:0]};
    endfunction

    always @(posedge clk) begin
        flush_seen = arst_n && flush;
        if (!arst_n || flush) begin
            armed    = 1'b0;
            edge_cnt = 0;
        end else if (armed) begin
            if (edge_cnt == result_edge) begin
                armed    = 1'b0;
                edge_cnt = 0;
            end else begin
                edge_cnt++;
            end
        end else if (valid && !valid_prev) begin
            armed    = 1'b1;
            edge_cnt = 1;
            a_cap    = a;
            b_cap    = b;
            sgn_cap  = is_signed;
        end
        valid_prev = valid;
    end

    // compare on the falling edge in the middle of the window
    always @(negedge clk) begin
        if (arst_n && !reset_checked) begin
            reset_checked = 1'b1;
            checks_n++;
            if (hilo !== 64'h0) begin
                errors_n++;
                $display("Error at %0d ns: hilo expected %h, actual %h (after reset)",
                         $time, 64'h0, hilo);
            end
        end
        // a flush clears the result register like reset
        if (flush_seen) begin
            checks_n++;
            if (hilo !== 64'h0) begin
                errors_n++;
                $display("Error at %0d ns: hilo expected %h, actual %h (after flush)",
                         $time, 64'h0, hilo);
            end
        end
        if (armed && edge_cnt == result_edge) begin
            exp_v = expected_hilo(a_cap, b_cap, sgn_cap);
            checks_n++;
            if (hilo !== exp_v) begin
                errors_n++;
                $display("Error at %0d ns: hilo expected %h, actual %h (a=%h b=%h signed=%0d)",
                         $time, exp_v, hilo, a_cap, b_cap, sgn_cap);
            end
        end
    end

endmodule

// File: div_core.sv
// unsigned divider engine with operand capture, 16 SRT iterations and remainder correction
module div_core (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            valid,
    input  div_pkg::word_t  a_mag,
    input  div_pkg::word_t  b_mag,
    output div_pkg::dword_t u_hilo
);
    import div_pkg::*;

    word_t  a_q;
    word_t  b_q;
    logic   valid_q;

    // iteration state
    pa_t    pa;
    word_t  b_norm;
    word_t  q;
    shift_t shift;

    pa_t    init_pa;
    word_t  init_b;
    shift_t init_shift;
    pa_t    step_pa;
    word_t  step_q;

    logic   rem_neg;
    word_t  rem_raw;
    word_t  rem_fix;
    word_t  q_fix;
    logic   div_one;
    dword_t result;

    div_normalize u_norm (
        .op_a       (a_q),
        .op_b       (b_q),
        .init_pa    (init_pa),
        .init_b     (init_b),
        .init_shift (init_shift)
    );

    div_step u_step (
        .pa_in  (pa),
        .q_in   (q),
        .b_norm (b_norm),
        .pa_out (step_pa),
        .q_out  (step_q)
    );

    // a negative remainder gets the divisor added back and the quotient decremented
    assign rem_neg = pa[pa_w-1];
    assign rem_raw = pa[pa_w-2 -: word_w];
    assign rem_fix = rem_neg ? rem_raw + b_norm : rem_raw;
    assign q_fix   = rem_neg ? q - 1'b1 : q;

    // divisor of one needs a quotient beyond the reach of 16 radix-4 digits
    assign div_one = (shift == shift_t'(word_w - 1));

    // undo the normalizing shift on the remainder only
    assign result  = div_one ? {word_t'(0), a_q} : {rem_fix >> shift, q_fix};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q     <= '0;
            b_q     <= '0;
            valid_q <= 1'b0;
            pa      <= '0;
            b_norm  <= '0;
            q       <= '0;
            shift   <= '0;
            u_hilo  <= '0;
        end else if (flush) begin
            a_q     <= '0;
            b_q     <= '0;
            valid_q <= 1'b0;
            pa      <= '0;
            b_norm  <= '0;
            q       <= '0;
            shift   <= '0;
            u_hilo  <= '0;
        end else begin
            a_q     <= a_mag;
            b_q     <= b_mag;
            valid_q <= valid;
            // load while idle and iterate while valid is held
            if (valid_q) begin
                pa <= step_pa;
                q  <= step_q;
            end else begin
                pa     <= init_pa;
                b_norm <= init_b;
                q      <= '0;
                shift  <= init_shift;
            end
            u_hilo  <= result;
        end
    end

endmodule

// File: div_digit_table.sv
// quotient-digit selection for one SRT step, looked up from divisor and remainder top bits
module div_digit_table (
    input  logic [div_pkg::table_b_bits-1:0]  b_top,
    input  logic [div_pkg::table_pa_bits-1:0] pa_top,
    output div_pkg::digit_t                   digit
);
    import div_pkg::*;

    // per-row bounds, highest entry first:
    // lowest -2, lowest -1, lowest 0, lowest +1, lowest +2, highest +2
    logic [5:0][table_pa_bits-1:0] bnd;

    logic signed [table_pa_bits-1:0] m2_lo;
    logic signed [table_pa_bits-1:0] m1_lo;
    logic signed [table_pa_bits-1:0] z_lo;
    logic signed [table_pa_bits-1:0] p1_lo;
    logic signed [table_pa_bits-1:0] p2_lo;
    logic signed [table_pa_bits-1:0] p2_hi;
    logic signed [table_pa_bits-1:0] pa_s;

    always_comb begin
        case (b_top)
            3'd0: bnd = {-6'sd12, -6'sd6, -6'sd2, 6'sd2, 6'sd6, 6'sd11};
            3'd1: bnd = {-6'sd14, -6'sd7, -6'sd2, 6'sd3, 6'sd7, 6'sd13};
            3'd2: bnd = {-6'sd15, -6'sd8, -6'sd2, 6'sd3, 6'sd8, 6'sd14};
            3'd3: bnd = {-6'sd16, -6'sd8, -6'sd2, 6'sd3, 6'sd9, 6'sd15};
            3'd4: bnd = {-6'sd18, -6'sd9, -6'sd3, 6'sd4, 6'sd10, 6'sd17};
            3'd5: bnd = {-6'sd19, -6'sd10, -6'sd3, 6'sd4, 6'sd10, 6'sd18};
            3'd6: bnd = {-6'sd20, -6'sd10, -6'sd3, 6'sd4, 6'sd11, 6'sd19};
            // divisor 1.111xxx, widest row
            default: bnd = {-6'sd22, -6'sd11, -6'sd3, 6'sd5, 6'sd12, 6'sd21};
        endcase
    end

    assign m2_lo = bnd[5];
    assign m1_lo = bnd[4];
    assign z_lo  = bnd[3];
    assign p1_lo = bnd[2];
    assign p2_lo = bnd[1];
    assign p2_hi = bnd[0];

    // partial remainder estimate, two's complement
    assign pa_s = pa_top;

    // regions are contiguous, so one lower bound per region is enough
    always_comb begin
        if (pa_s < m2_lo || pa_s > p2_hi) begin
            digit = digit_bad;
        end else if (pa_s < m1_lo) begin
            digit = digit_m2;
        end else if (pa_s < z_lo) begin
            digit = digit_m1;
        end else if (pa_s < p1_lo) begin
            digit = digit_0;
        end else if (pa_s < p2_lo) begin
            digit = digit_p1;
        end else begin
            digit = digit_p2;
        end
    end

endmodule

// File: div_normalize.sv
// divisor normalization, shifts divisor and dividend left until the divisor msb is set
module div_normalize (
    input  div_pkg::word_t  op_a,
    input  div_pkg::word_t  op_b,
    output div_pkg::pa_t    init_pa,
    output div_pkg::word_t  init_b,
    output div_pkg::shift_t init_shift
);
    import div_pkg::*;

    logic   found;
    shift_t lead_shift;
    pa_t    a_ext;

    // priority search from the msb down, first hit wins
    always_comb begin
        found      = 1'b0;
        lead_shift = '0;
        for (int i = word_w - 1; i >= 0; i--) begin
            if (!found && op_b[i]) begin
                found      = 1'b1;
                lead_shift = shift_t'(word_w - 1 - i);
            end
        end
    end

    // dividend sits in the low word, upper half starts at zero
    assign a_ext = pa_t'(op_a);

    // zero divisor: everything zero, result undefined
    assign init_shift = found ? lead_shift : '0;
    assign init_b     = found ? op_b << lead_shift : '0;
    assign init_pa    = found ? a_ext << lead_shift : '0;

endmodule

// File: div_pkg.sv
// shared widths, types and quotient-digit encoding for the radix-4 SRT divider RTL
package div_pkg;

    // two quotient bits retired per iteration
    localparam int n_steps = 16;

    // operand width follows from the iteration count
    localparam int word_w = 2 * n_steps;

    // partial remainder plus shifted dividend, with a sign bit on top
    localparam int pa_w = 2 * word_w + 1;

    // divisor bits just below the leading one
    localparam int table_b_bits = 3;

    // top bits of the partial remainder, sign included
    localparam int table_pa_bits = 6;

    // operand, quotient or remainder
    typedef logic [word_w-1:0] word_t;

    // {hi, lo} = {remainder, quotient}
    typedef logic [2*word_w-1:0] dword_t;

    // upper word_w+1 bits hold the signed partial remainder,
    // lower word_w bits the dividend bits not yet consumed
    typedef logic [pa_w-1:0] pa_t;

    // normalization shift, 0 to word_w-1
    typedef logic [4:0] shift_t;

    // redundant radix-4 digit set {-2..+2}
    // digit_bad flags a lookup outside every region of the row
    typedef enum logic [2:0] {
        digit_m2  = 3'd0,
        digit_m1  = 3'd1,
        digit_0   = 3'd2,
        digit_p1  = 3'd3,
        digit_p2  = 3'd4,
        digit_bad = 3'd5
    } digit_t;

endpackage

// File: div_step.sv
// one radix-4 SRT iteration, next partial remainder and quotient from the current state
module div_step (
    input  div_pkg::pa_t   pa_in,
    input  div_pkg::word_t q_in,
    input  div_pkg::word_t b_norm,
    output div_pkg::pa_t   pa_out,
    output div_pkg::word_t q_out
);
    import div_pkg::*;

    digit_t            digit;
    pa_t               pa_sh;
    logic [word_w:0]   upper;
    logic [word_w:0]   b_x1;
    logic [word_w:0]   b_x2;
    logic [word_w:0]   upper_next;

    // lookup uses the bits below the implicit leading one of the divisor
    div_digit_table u_table (
        .b_top  (b_norm[word_w-2 -: table_b_bits]),
        .pa_top (pa_in[pa_w-1 -: table_pa_bits]),
        .digit  (digit)
    );

    assign pa_sh = pa_in << 2;
    assign upper = pa_sh[pa_w-1 -: word_w+1];
    assign b_x1  = {1'b0, b_norm};
    assign b_x2  = {b_norm, 1'b0};

    // negative digits borrow from the quotient bits already formed
    always_comb begin
        case (digit)
            digit_p2: begin
                upper_next = upper - b_x2;
                q_out      = {q_in[word_w-3:0], 2'b10};
            end
            digit_p1: begin
                upper_next = upper - b_x1;
                q_out      = {q_in[word_w-3:0], 2'b01};
            end
            digit_0: begin
                upper_next = upper;
                q_out      = {q_in[word_w-3:0], 2'b00};
            end
            digit_m1: begin
                upper_next = upper + b_x1;
                q_out      = {q_in[word_w-3:0] - 1'b1, 2'b11};
            end
            digit_m2: begin
                upper_next = upper + b_x2;
                q_out      = {q_in[word_w-3:0] - 1'b1, 2'b10};
            end
            default: begin
                upper_next = '0;
                q_out      = '0;
            end
        endcase
    end

    assign pa_out = {upper_next, pa_sh[word_w-1:0]};

endmodule

// File: div_top.sv
// signed and unsigned 32-bit divider top level, {remainder, quotient} on hilo
module div_top (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            flush,
    input  logic            valid,
    input  div_pkg::word_t  a,
    input  div_pkg::word_t  b,
    input  logic            is_signed,
    output div_pkg::dword_t hilo
);
    import div_pkg::*;

    logic   a_neg;
    logic   b_neg;
    word_t  a_mag;
    word_t  b_mag;
    dword_t u_hilo;

    assign a_neg = is_signed & a[word_w-1];
    assign b_neg = is_signed & b[word_w-1];
    assign a_mag = a_neg ? -a : a;
    assign b_mag = b_neg ? -b : b;

    div_core u_core (
        .clk    (clk),
        .arst_n (arst_n),
        .flush  (flush),
        .valid  (valid),
        .a_mag  (a_mag),
        .b_mag  (b_mag),
        .u_hilo (u_hilo)
    );

    // quotient truncates toward zero
    assign hilo[word_w-1:0] = (a_neg ^ b_neg) ? -u_hilo[word_w-1:0]
                                              : u_hilo[word_w-1:0];

    // remainder follows the dividend sign
    assign hilo[2*word_w-1:word_w] = a_neg ? -u_hilo[2*word_w-1:word_w]
                                           : u_hilo[2*word_w-1:word_w];

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_div \
    -f sources.f -o tb_div 2>&1 && ./obj_dir/tb_div 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed" && exit 0 || exit 1

// File: sources.f
div_pkg.sv
div_digit_table.sv
div_normalize.sv
div_step.sv
div_core.sv
div_top.sv
div_checker.sv
tb_div.sv

// File: tb_div.sv
// divider testbench that runs table and random operations and reports the checker's counts
module tb_div;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_random     = 40;
    localparam int op_cycles    = 22;
    localparam int clk_period   = 10;
    localparam int seed         = 28;
    localparam int valid_cycles = 18;
    localparam int flush_after  = 8;

    typedef struct {
        logic [31:0] a;
        logic [31:0] b;
        logic        sgn;
        logic        flush_mid;
    } op_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        flush;
    logic        valid;
    logic [31:0] a;
    logic [31:0] b;
    logic        is_signed;
    logic [63:0] hilo;
    int          checks;
    int          errors;
    int          n_expected;
    int          limit_ns = 0;
    op_t         ops[$];

    always #(clk_period / 2) clk = ~clk;

    div_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .valid     (valid),
        .a         (a),
        .b         (b),
        .is_signed (is_signed),
        .hilo      (hilo)
    );

    div_checker u_chk (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .valid     (valid),
        .a         (a),
        .b         (b),
        .is_signed (is_signed),
        .hilo      (hilo),
        .checks    (checks),
        .errors    (errors)
    );

    task automatic add_case(input logic [31:0] x, input logic [31:0] y,
                            input logic s, input logic f);
        op_t op;
        op.a         = x;
        op.b         = y;
        op.sgn       = s;
        op.flush_mid = f;
        ops.push_back(op);
    endtask

    task automatic build_table();
        logic [31:0] low;
        add_case(32'd100, 32'd7, 1'b0, 1'b0);
        add_case(32'd5, 32'd9, 1'b0, 1'b0);
        add_case(32'hdeadbeef, 32'd1, 1'b0, 1'b0);
        add_case(32'd0, 32'd12345, 1'b0, 1'b0);
        add_case(32'hffffffff, 32'd3, 1'b0, 1'b0);
        add_case(32'hffffffff, 32'hffffffff, 1'b0, 1'b0);
        add_case(32'h80000000, 32'hffffffff, 1'b0, 1'b0);
        add_case(32'h12345678, 32'd91, 1'b0, 1'b1);
        add_case(32'h12345678, 32'd91, 1'b0, 1'b0);
        // leading one at each position with varied low bits to reach all table rows
        for (int i = 0; i < 32; i++) begin
            low = (32'h9e3779b9 * (i + 1)) & ((32'h1 << i) - 1);
            add_case(32'hf0e1d2c3 ^ (32'h01010101 * i), (32'h1 << i) | low, 1'b0, 1'b0);
        end
        add_case(32'd100, 32'd7, 1'b1, 1'b0);
        add_case(32'hffffff9c, 32'd7, 1'b1, 1'b0);
        add_case(32'd100, 32'hfffffff9, 1'b1, 1'b0);
        add_case(32'hffffff9c, 32'hfffffff9, 1'b1, 1'b0);
        add_case(32'h80000000, 32'd1, 1'b1, 1'b0);
        add_case(32'h80000000, 32'hffffffff, 1'b1, 1'b0);
        add_case(32'hffffffff, 32'd2, 1'b1, 1'b0);
        add_case(32'd7, 32'hffffff9c, 1'b1, 1'b0);
        add_case(32'h7fffffff, 32'hffffffff, 1'b1, 1'b0);
        add_case(32'h87654321, 32'hfffffffd, 1'b1, 1'b1);
        add_case(32'h87654321, 32'hfffffffd, 1'b1, 1'b0);
    endtask

    // enters and leaves 1 ns after a rising edge
    task automatic run_op(input logic [31:0] x, input logic [31:0] y,
                          input logic s, input logic f);
        a         = x;
        b         = y;
        is_signed = s;
        valid     = 1'b0;
        @(posedge clk);
        #1;
        valid = 1'b1;
        if (f) begin
            repeat (flush_after) @(posedge clk);
            #1;
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
        end else begin
            repeat (valid_cycles) @(posedge clk);
            #1;
        end
        valid = 1'b0;
        // operands stay put while hilo is still in its window
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic        rs;
        arst_n     = 1'b0;
        flush      = 1'b0;
        valid      = 1'b0;
        a          = '0;
        b          = '0;
        is_signed  = 1'b0;
        void'($urandom(seed));
        build_table();
        // each table entry yields one check on its result or on the hilo cleared by its flush
        n_expected = n_random + 1 + ops.size();
        limit_ns = ((ops.size() + n_random) * op_cycles + 20) * clk_period;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        foreach (ops[i]) begin
            run_op(ops[i].a, ops[i].b, ops[i].sgn, ops[i].flush_mid);
        end
        for (int i = 0; i < n_random; i++) begin
            ra = $urandom;
            rb = $urandom >> ($urandom % 32);
            if (rb == 0) begin
                rb = 32'd1;
            end
            rs = 1'($urandom % 2);
            run_op(ra, rb, rs, 1'b0);
        end
        repeat (3) @(posedge clk);
        if (checks != n_expected) begin
            $display("not every operation produced a checked result");
        end
        $display("checks: %0d of %0d, errors: %0d", checks, n_expected, errors);
        if (errors == 0 && checks == n_expected) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog limit follows the number of operations
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("tests failed");
        $finish;
    end

endmodule
